/* Makefile */
.PHONY: all run lint clean

all: run

obj_dir/sim: all.f
	verilator --binary --timing --assert -f all.f --top-module risc8_tb --Mdir obj_dir -o sim

run: obj_dir/sim
	./obj_dir/sim > sim.log 2>&1 || true
	cat sim.log
	! grep -q "CHECKS FAILED" sim.log
	grep -q "ALL CHECKS PASSED" sim.log

lint:
	verilator --lint-only -Wall design/risc8_pkg.sv design/risc8_decode.sv design/risc8_sequencer.sv design/risc8_pc.sv design/risc8_regs.sv design/risc8_alu.sv design/risc8_core.sv --top-module risc8_core

clean:
	rm -rf obj_dir sim.log

/* all.f */
design/risc8_pkg.sv
design/risc8_decode.sv
design/risc8_sequencer.sv
design/risc8_pc.sv
design/risc8_regs.sv
design/risc8_alu.sv
design/risc8_core.sv
bench/risc8_tb.sv

/* bench/risc8_tb.sv */
// ============================================================================
// Testbench of the two-stage RISC-8 core.
// Each table row is turned into a short program in the ROM model, the core
// is reset and the bus writes it makes are compared with values derived
// from the AVR flag rules. Rows with a zero operand draw it at random.
// ============================================================================
`timescale 1ns/10ps

module risc8_tb;

	// row kinds
	localparam logic [2:0] K_ALU = 3'd0;
	localparam logic [2:0] K_BRANCH = 3'd1;
	localparam logic [2:0] K_RJMP = 3'd2;
	localparam logic [2:0] K_IO = 3'd3;
	localparam logic [2:0] K_SREG = 3'd4;
	// operations
	localparam logic [3:0] T_ADD = 4'd0;
	localparam logic [3:0] T_ADC = 4'd1;
	localparam logic [3:0] T_SUB = 4'd2;
	localparam logic [3:0] T_SBC = 4'd3;
	localparam logic [3:0] T_AND = 4'd4;
	localparam logic [3:0] T_OR = 4'd5;
	localparam logic [3:0] T_EOR = 4'd6;
	localparam logic [3:0] T_MOV = 4'd7;
	localparam logic [3:0] T_CP = 4'd8;
	localparam logic [3:0] T_BRBS = 4'd9;
	localparam logic [3:0] T_BRBC = 4'd10;
	localparam int NUM_CASES = 20;
	// RJMP to itself
	localparam logic [15:0] HALT = 16'hCFFF;

	typedef struct packed {
		logic [2:0] kind;
		logic [3:0] op;
		logic [2:0] sbit;
		logic [7:0] a;
		logic [7:0] b;
		logic [7:0] exp_out;
		logic [7:0] exp_flags;
		logic known;
	} case_t;

	typedef struct packed {
		logic [15:0] addr;
		logic [7:0] data;
	} bus_write_t;

	logic clk;
	logic reset;
	logic [15:0] pc;
	logic [15:0] cdata;
	logic [15:0] data_addr;
	logic data_ren;
	logic data_wen;
	logic [7:0] data_write;
	logic [7:0] data_read;

	logic [15:0] rom [0:63];
	logic [7:0] io_key;
	case_t cases [0:NUM_CASES-1];
	bus_write_t expect_q [$];
	logic failed;
	int seed_val;

	risc8_core dut (
		.clk(clk),
		.reset(reset),
		.pc(pc),
		.cdata(cdata),
		.data_addr(data_addr),
		.data_ren(data_ren),
		.data_wen(data_wen),
		.data_write(data_write),
		.data_read(data_read)
	);

	always #2 clk = ~clk;

	// data memory pattern, depends on the whole address
	function automatic logic [7:0] fill_byte(input logic [15:0] addr, input logic [7:0] key);
		return addr[7:0] ^ addr[15:8] ^ key ^ 8'hA5;
	endfunction

	// program ROM and data memory, read data one clock after data_ren
	always @(posedge clk) begin
		cdata <= rom[pc[5:0]];
		if (data_ren)
			data_read <= fill_byte(data_addr, io_key);
	end

	// AVR opcode encoders
	function automatic logic [15:0] enc_rr(input logic [5:0] top, input logic [4:0] d,
		input logic [4:0] r);
		return {top, r[4], d, r[3:0]};
	endfunction

	function automatic logic [15:0] enc_ldi(input logic [4:0] d, input logic [7:0] k);
		return {4'hE, k[7:4], d[3:0], k[3:0]};
	endfunction

	function automatic logic [15:0] enc_out(input logic [5:0] io, input logic [4:0] r);
		return {5'b10111, io[5:4], r, io[3:0]};
	endfunction

	function automatic logic [15:0] enc_in(input logic [4:0] d, input logic [5:0] io);
		return {5'b10110, io[5:4], d, io[3:0]};
	endfunction

	function automatic logic [5:0] op_top(input logic [3:0] op);
		case (op)
		T_ADD: return 6'b000011;
		T_ADC: return 6'b000111;
		T_SUB: return 6'b000110;
		T_SBC: return 6'b000010;
		T_AND: return 6'b001000;
		T_EOR: return 6'b001001;
		T_OR: return 6'b001010;
		T_MOV: return 6'b001011;
		default: return 6'b000101;
		endcase
	endfunction

	// expected {result, status} from the flag rules
	function automatic logic [15:0] model_alu(input logic [3:0] op, input logic [7:0] a,
		input logic [7:0] b, input logic [7:0] sreg);
		int cin;
		int u;
		int s;
		logic [7:0] r;
		logic c;
		logic v;
		logic z;
		logic n;
		cin = (op == T_ADC || op == T_SBC) ? int'(sreg[0]) : 0;
		c = sreg[0];
		v = 1'b0;
		r = b;
		if (op == T_ADD || op == T_ADC) begin
			u = int'(a) + int'(b) + cin;
			s = int'($signed(a)) + int'($signed(b)) + cin;
			r = u[7:0];
			c = (u > 255);
			v = (s > 127 || s < -128);
		end else if (op == T_SUB || op == T_SBC || op == T_CP) begin
			u = int'(a) - int'(b) - cin;
			s = int'($signed(a)) - int'($signed(b)) - cin;
			r = u[7:0];
			c = (u < 0);
			v = (s > 127 || s < -128);
		end else if (op == T_AND) begin
			r = a & b;
		end else if (op == T_OR) begin
			r = a | b;
		end else if (op == T_EOR) begin
			r = a ^ b;
		end
		// SBC keeps Z only when it was already set
		z = (r == 8'd0) && (op != T_SBC || sreg[1]);
		n = r[7];
		if (op == T_MOV)
			return {r, sreg};
		return {r, 3'b000, n ^ v, v, n, z, c};
	endfunction

	task automatic halt_run();
		failed = 1'b1;
		$display("CHECKS FAILED");
		$fatal(1, "stopped at first error");
	endtask

	task automatic value_error(input string name, input logic [15:0] got,
		input logic [15:0] exp);
		$display("FAIL at %0t ns: %s is 0x%0h, expected 0x%0h", $time, name, got, exp);
		halt_run();
	endtask

	task automatic other_error(input string what);
		$display("%s at %0t ns", what, $time);
		halt_run();
	endtask

	// fills the ROM and the list of bus writes for one row
	task automatic load_program(input case_t c, input logic [7:0] a, input logic [7:0] b);
		logic [15:0] m;
		logic [7:0] out_val;
		logic [7:0] marker;
		for (int i = 0; i < 64; i++)
			rom[i] = 16'h0000;
		expect_q.delete();
		io_key = a;
		case (c.kind)
		K_ALU: begin
			m = model_alu(c.op, a, b, 8'h00);
			out_val = (c.op == T_CP) ? a : m[15:8];
			if (c.known) begin
				assert (out_val == c.exp_out) else value_error("table exp_out", c.exp_out, out_val);
				assert (m[7:0] == c.exp_flags) else value_error("table exp_flags", c.exp_flags, m[7:0]);
			end
			rom[0] = enc_ldi(5'd16, a);
			rom[1] = enc_ldi(5'd17, b);
			rom[2] = enc_rr(op_top(c.op), 5'd16, 5'd17);
			rom[3] = enc_out(6'h01, 5'd16);
			rom[4] = enc_in(5'd18, 6'h3F);
			rom[5] = enc_out(6'h02, 5'd18);
			rom[6] = HALT;
			expect_q.push_back('{16'h0021, out_val});
			expect_q.push_back('{16'h0022, m[7:0]});
		end
		K_BRANCH: begin
			m = model_alu(T_CP, a, b, 8'h00);
			// BRBS jumps on a set bit, BRBC on a clear one
			marker = (m[c.sbit] == (c.op == T_BRBS)) ? 8'h22 : 8'h11;
			if (c.known) begin
				assert (marker == c.exp_out) else value_error("table exp_out", c.exp_out, marker);
				assert (m[7:0] == c.exp_flags) else value_error("table exp_flags", c.exp_flags, m[7:0]);
			end
			rom[0] = enc_ldi(5'd16, a);
			rom[1] = enc_ldi(5'd17, b);
			rom[2] = enc_rr(op_top(T_CP), 5'd16, 5'd17);
			rom[3] = {5'b11110, c.op == T_BRBC, 7'd2, c.sbit};
			rom[4] = enc_ldi(5'd19, 8'h11);
			rom[5] = 16'hC001;
			rom[6] = enc_ldi(5'd19, 8'h22);
			rom[7] = enc_out(6'h01, 5'd19);
			rom[8] = enc_in(5'd18, 6'h3F);
			rom[9] = enc_out(6'h02, 5'd18);
			rom[10] = HALT;
			expect_q.push_back('{16'h0021, marker});
			expect_q.push_back('{16'h0022, m[7:0]});
		end
		K_RJMP: begin
			// the OUT to 0x04 sits in the jumped-over slot
			rom[0] = enc_ldi(5'd16, a);
			rom[1] = 16'hC001;
			rom[2] = enc_out(6'h04, 5'd16);
			rom[3] = enc_out(6'h01, 5'd16);
			rom[4] = HALT;
			expect_q.push_back('{16'h0021, a});
		end
		K_IO: begin
			rom[0] = enc_in(5'd20, 6'h05);
			rom[1] = enc_out(6'h03, 5'd20);
			rom[2] = HALT;
			expect_q.push_back('{16'h0023, fill_byte(16'h0025, a)});
		end
		default: begin
			// status register round trip, no bus write at 0x5F
			if (c.known)
				assert ((a & 8'h1F) == c.exp_out)
					else value_error("table exp_out", c.exp_out, a & 8'h1F);
			rom[0] = enc_ldi(5'd16, a);
			rom[1] = enc_out(6'h3F, 5'd16);
			rom[2] = enc_in(5'd18, 6'h3F);
			rom[3] = enc_out(6'h02, 5'd18);
			rom[4] = HALT;
			expect_q.push_back('{16'h0022, a & 8'h1F});
		end
		endcase
	endtask

	task automatic run_case(input case_t c);
		logic [7:0] a;
		logic [7:0] b;
		bus_write_t w;
		int cyc;
		a = (c.a == 8'd0) ? 8'($urandom) : c.a;
		b = (c.b == 8'd0) ? 8'($urandom) : c.b;
		@(posedge clk);
		reset <= 1'b1;
		load_program(c, a, b);
		repeat (2) @(posedge clk);
		@(negedge clk);
		assert (pc == 16'h0000) else value_error("pc", pc, 16'h0000);
		assert (!data_ren) else value_error("data_ren", 16'(data_ren), 16'h0);
		assert (!data_wen) else value_error("data_wen", 16'(data_wen), 16'h0);
		repeat (2) @(posedge clk);
		reset <= 1'b0;
		cyc = 0;
		while (expect_q.size() > 0 && cyc < 80) begin
			@(negedge clk);
			if ((c.kind == K_ALU || c.kind == K_BRANCH) && cyc < 3)
				assert (pc == 16'(cyc)) else value_error("pc", pc, 16'(cyc));
			if (c.kind != K_IO) begin
				assert (!data_ren) else value_error("data_ren", 16'(data_ren), 16'h0);
			end else if (data_ren) begin
				// the only read goes to I/O 0x05
				assert (data_addr == 16'h0025)
					else value_error("data_addr", data_addr, 16'h0025);
			end
			if (data_wen) begin
				w = expect_q.pop_front();
				assert (data_addr == w.addr) else value_error("data_addr", data_addr, w.addr);
				assert (data_write == w.data)
					else value_error("data_write", 16'(data_write), 16'(w.data));
			end
			cyc++;
		end
		if (expect_q.size() > 0)
			other_error("timed out waiting for a bus write");
	endtask

	initial begin
		clk = 1'b0;
		reset = 1'b1;
		cdata = 16'h0000;
		data_read = 8'h00;
		io_key = 8'h00;
		failed = 1'b0;
		seed_val = $urandom(4186);
		for (int i = 0; i < 64; i++)
			rom[i] = 16'h0000;
		// kind, op, status bit, a, b, expected out, expected flags, expected given
		cases[0] = '{K_ALU, T_ADD, 3'd0, 8'h3C, 8'h0F, 8'h4B, 8'h00, 1'b1};
		cases[1] = '{K_ALU, T_ADD, 3'd0, 8'h80, 8'h80, 8'h00, 8'h1B, 1'b1};
		cases[2] = '{K_ALU, T_ADC, 3'd0, 8'h01, 8'hFF, 8'h00, 8'h03, 1'b1};
		cases[3] = '{K_ALU, T_SUB, 3'd0, 8'h10, 8'h20, 8'hF0, 8'h15, 1'b1};
		cases[4] = '{K_ALU, T_SUB, 3'd0, 8'h00, 8'h00, 8'h00, 8'h00, 1'b0};
		cases[5] = '{K_ALU, T_SBC, 3'd0, 8'h00, 8'h00, 8'h00, 8'h00, 1'b0};
		cases[6] = '{K_ALU, T_AND, 3'd0, 8'hF0, 8'h3C, 8'h30, 8'h00, 1'b1};
		cases[7] = '{K_ALU, T_OR, 3'd0, 8'h00, 8'h00, 8'h00, 8'h00, 1'b0};
		cases[8] = '{K_ALU, T_EOR, 3'd0, 8'h55, 8'h55, 8'h00, 8'h02, 1'b1};
		cases[9] = '{K_ALU, T_MOV, 3'd0, 8'h00, 8'h00, 8'h00, 8'h00, 1'b0};
		cases[10] = '{K_ALU, T_CP, 3'd0, 8'h05, 8'h05, 8'h05, 8'h02, 1'b1};
		cases[11] = '{K_BRANCH, T_BRBS, 3'd1, 8'h07, 8'h07, 8'h22, 8'h02, 1'b1};
		cases[12] = '{K_BRANCH, T_BRBC, 3'd0, 8'h03, 8'h09, 8'h11, 8'h15, 1'b1};
		cases[13] = '{K_BRANCH, T_BRBS, 3'd0, 8'h09, 8'h03, 8'h11, 8'h00, 1'b1};
		cases[14] = '{K_BRANCH, T_BRBC, 3'd2, 8'h00, 8'h00, 8'h00, 8'h00, 1'b0};
		cases[15] = '{K_RJMP, T_ADD, 3'd0, 8'h00, 8'h00, 8'h00, 8'h00, 1'b0};
		cases[16] = '{K_IO, T_ADD, 3'd0, 8'h00, 8'h00, 8'h00, 8'h00, 1'b0};
		cases[17] = '{K_IO, T_ADD, 3'd0, 8'h3E, 8'h00, 8'h00, 8'h00, 1'b0};
		cases[18] = '{K_SREG, T_ADD, 3'd0, 8'hEA, 8'h00, 8'h0A, 8'h00, 1'b1};
		cases[19] = '{K_SREG, T_ADD, 3'd0, 8'h00, 8'h00, 8'h00, 8'h00, 1'b0};
		for (int i = 0; i < NUM_CASES; i++)
			run_case(cases[i]);
		if (!failed) begin
			$display("ALL CHECKS PASSED");
			$finish;
		end else begin
			halt_run();
		end
	end

	// overall limit on the run
	initial begin
		#50000;
		other_error("simulation ran past its time limit");
	end

endmodule

/* design/risc8_alu.sv */
// ============================================================================
// Second stage of the RISC-8 core.
// Latches the decoder's control word, runs the operation on the register
// operands or the constant, and drives the write port back to the
// register file. Owns the status register and its next value.
// ============================================================================
`timescale 1ns/10ps

module risc8_alu (
	input logic clk,
	input logic reset,
	input risc8_pkg::alu_ctl_t alu_ctl,
	input risc8_pkg::byte_t reg_a,
	input risc8_pkg::byte_t reg_b,
	output risc8_pkg::reg_sel_t wsel,
	output logic wen,
	output risc8_pkg::byte_t wdata,
	output risc8_pkg::byte_t sreg_next
);
	risc8_pkg::alu_ctl_t ctl_q;
	risc8_pkg::byte_t sreg_q;
	risc8_pkg::byte_t opnd_b;
	risc8_pkg::byte_t result;
	logic [8:0] wide;
	logic carry_in;
	logic flag_c;
	logic flag_v;
	logic flag_z;
	logic flag_n;
	logic update;

	always_comb begin
		opnd_b = ctl_q.use_const ? ctl_q.const_val : reg_b;
		carry_in = ctl_q.use_carry & sreg_q[risc8_pkg::FLAG_C];
		wide = '0;
		result = opnd_b;
		flag_c = sreg_q[risc8_pkg::FLAG_C];
		flag_v = sreg_q[risc8_pkg::FLAG_V];
		update = 1'b0;

		case (ctl_q.op)
		risc8_pkg::OP_ADD, risc8_pkg::OP_ADC: begin
			wide = {1'b0, reg_a} + {1'b0, opnd_b} + {8'd0, carry_in};
			result = wide[7:0];
			flag_c = wide[8];
			flag_v = (reg_a[7] & opnd_b[7] & ~result[7]) | (~reg_a[7] & ~opnd_b[7] & result[7]);
			update = 1'b1;
		end
		risc8_pkg::OP_SUB, risc8_pkg::OP_SBC: begin
			// bit 8 of the difference is the borrow
			wide = {1'b0, reg_a} - {1'b0, opnd_b} - {8'd0, carry_in};
			result = wide[7:0];
			flag_c = wide[8];
			flag_v = (reg_a[7] & ~opnd_b[7] & ~result[7]) | (~reg_a[7] & opnd_b[7] & result[7]);
			update = 1'b1;
		end
		risc8_pkg::OP_AND: begin
			result = reg_a & opnd_b;
			flag_v = 1'b0;
			update = 1'b1;
		end
		risc8_pkg::OP_OR: begin
			result = reg_a | opnd_b;
			flag_v = 1'b0;
			update = 1'b1;
		end
		risc8_pkg::OP_EOR: begin
			result = reg_a ^ opnd_b;
			flag_v = 1'b0;
			update = 1'b1;
		end
		risc8_pkg::OP_SREG_LOAD: result = reg_a;
		default: begin
			// moves and the status read pass operand b
		end
		endcase

		// SBC chains Z across bytes
		flag_z = (result == 8'd0) & (ctl_q.op != risc8_pkg::OP_SBC || sreg_q[risc8_pkg::FLAG_Z]);
		flag_n = result[7];

		sreg_next = sreg_q;
		if (update) begin
			sreg_next = '0;
			sreg_next[risc8_pkg::FLAG_C] = flag_c;
			sreg_next[risc8_pkg::FLAG_Z] = flag_z;
			sreg_next[risc8_pkg::FLAG_N] = flag_n;
			sreg_next[risc8_pkg::FLAG_V] = flag_v;
			sreg_next[risc8_pkg::FLAG_S] = flag_n ^ flag_v;
		end else if (ctl_q.op == risc8_pkg::OP_SREG_LOAD) begin
			sreg_next = {3'b000, reg_a[4:0]};
		end
	end

	assign wsel = ctl_q.dest;
	assign wen = ctl_q.store;
	assign wdata = result;

	always_ff @(posedge clk) begin
		if (reset) begin
			ctl_q <= '{op: risc8_pkg::OP_MOVE, default: '0};
			sreg_q <= '0;
		end else begin
			ctl_q <= alu_ctl;
			sreg_q <= sreg_next;
		end
	end

	// an OUT to the status register never writes Rd back
	a_sreg_load_no_write: assert property (@(posedge clk) disable iff (reset)
		alu_ctl.op == risc8_pkg::OP_SREG_LOAD |=> !wen);

endmodule

/* design/risc8_core.sv */
// ============================================================================
// Top level of the two-stage RISC-8 core.
// Program memory returns one opcode per clock for the previous pc.
// The data bus carries IN and OUT with plain strobes, read data is
// expected one clock after data_ren.
// ============================================================================
`timescale 1ns/10ps

module risc8_core (
	input logic clk,
	input logic reset,
	output risc8_pkg::addr_t pc,
	input risc8_pkg::opcode_t cdata,
	output risc8_pkg::addr_t data_addr,
	output logic data_ren,
	output logic data_wen,
	output risc8_pkg::byte_t data_write,
	input risc8_pkg::byte_t data_read
);
	risc8_pkg::opcode_t opcode;
	risc8_pkg::seq_state_e state;
	risc8_pkg::instr_class_e instr_class;
	logic hold;
	risc8_pkg::reg_sel_t sel_a;
	risc8_pkg::reg_sel_t sel_b;
	risc8_pkg::byte_t reg_a;
	risc8_pkg::byte_t reg_b;
	risc8_pkg::alu_ctl_t alu_ctl;
	risc8_pkg::bus_req_t bus_req;
	risc8_pkg::branch_req_t branch_req;
	risc8_pkg::reg_sel_t wsel;
	logic wen;
	risc8_pkg::byte_t wdata;
	risc8_pkg::byte_t sreg_next;

	// bus strobes go straight out from the decoder
	assign data_addr = bus_req.addr;
	assign data_ren = bus_req.ren;
	assign data_wen = bus_req.wen;
	assign data_write = bus_req.wdata;

	risc8_sequencer u_sequencer (
		.clk(clk),
		.reset(reset),
		.cdata(cdata),
		.instr_class(instr_class),
		.state(state),
		.opcode(opcode),
		.hold(hold)
	);

	// first stage
	risc8_decode u_decode (
		.opcode(opcode),
		.state(state),
		.data_read(data_read),
		.reg_a(reg_a),
		.sreg_next(sreg_next),
		.instr_class(instr_class),
		.sel_a(sel_a),
		.sel_b(sel_b),
		.alu_ctl(alu_ctl),
		.bus_req(bus_req),
		.branch_req(branch_req)
	);

	risc8_pc u_pc (
		.clk(clk),
		.reset(reset),
		.hold(hold),
		.branch_req(branch_req),
		.sreg_next(sreg_next),
		.pc(pc)
	);

	risc8_regs u_regs (
		.clk(clk),
		.sel_a(sel_a),
		.sel_b(sel_b),
		.reg_a(reg_a),
		.reg_b(reg_b),
		.wsel(wsel),
		.wen(wen),
		.wdata(wdata)
	);

	// second stage
	risc8_alu u_alu (
		.clk(clk),
		.reset(reset),
		.alu_ctl(alu_ctl),
		.reg_a(reg_a),
		.reg_b(reg_b),
		.wsel(wsel),
		.wen(wen),
		.wdata(wdata),
		.sreg_next(sreg_next)
	);

endmodule

/* design/risc8_decode.sv */
// ============================================================================
// First-stage decoder of the RISC-8 core.
// Purely combinational: classifies the current opcode and turns it into
// register selects, the ALU control word, the bus request and the jump
// request. IN and OUT use the sequencer state to split their two clocks.
// ============================================================================
`timescale 1ns/10ps

module risc8_decode (
	input risc8_pkg::opcode_t opcode,
	input risc8_pkg::seq_state_e state,
	input risc8_pkg::byte_t data_read,
	input risc8_pkg::byte_t reg_a,
	input risc8_pkg::byte_t sreg_next,
	output risc8_pkg::instr_class_e instr_class,
	output risc8_pkg::reg_sel_t sel_a,
	output risc8_pkg::reg_sel_t sel_b,
	output risc8_pkg::alu_ctl_t alu_ctl,
	output risc8_pkg::bus_req_t bus_req,
	output risc8_pkg::branch_req_t branch_req
);
	// opcode fields
	risc8_pkg::reg_sel_t rd;
	risc8_pkg::reg_sel_t rr;
	risc8_pkg::reg_sel_t rdi;
	risc8_pkg::byte_t k;
	risc8_pkg::io_addr_t io_addr;
	risc8_pkg::addr_t io_data_addr;
	logic is_sreg_io;

	assign rd = opcode[8:4];
	assign rr = {opcode[9], opcode[3:0]};
	// LDI only reaches r16 to r31
	assign rdi = {1'b1, opcode[7:4]};
	assign k = {opcode[11:8], opcode[3:0]};
	assign io_addr = {opcode[10:9], opcode[3:0]};
	assign io_data_addr = risc8_pkg::IO_BASE + risc8_pkg::addr_t'(io_addr);
	// status register lives in the core, never on the bus
	assign is_sreg_io = (io_addr == risc8_pkg::SREG_IO);

	// instruction family from the top six bits
	always_comb begin
		casez (opcode[15:10])
		6'b000011, 6'b000111, 6'b000110, 6'b000010,
		6'b001000, 6'b001001, 6'b001010, 6'b001011,
		6'b000101: instr_class = risc8_pkg::CLASS_ALU;
		6'b1110??: instr_class = risc8_pkg::CLASS_LDI;
		6'b1100??: instr_class = risc8_pkg::CLASS_RJMP;
		6'b11110?: instr_class = risc8_pkg::CLASS_BRANCH;
		6'b10111?: instr_class = risc8_pkg::CLASS_OUT;
		6'b10110?: instr_class = risc8_pkg::CLASS_IN;
		default: instr_class = risc8_pkg::CLASS_NOP;
		endcase
	end

	always_comb begin
		// default is a move into Rd that is not stored, which keeps the flags
		sel_a = rd;
		sel_b = rr;
		alu_ctl = '{op: risc8_pkg::OP_MOVE, dest: rd, default: '0};
		bus_req = '0;
		branch_req = '0;

		case (instr_class)
		risc8_pkg::CLASS_ALU: begin
			// CP shares SUB and drops the store
			alu_ctl.store = 1'b1;
			case (opcode[13:10])
			4'b0011: alu_ctl.op = risc8_pkg::OP_ADD;
			4'b0111: begin
				alu_ctl.op = risc8_pkg::OP_ADC;
				alu_ctl.use_carry = 1'b1;
			end
			4'b0110: alu_ctl.op = risc8_pkg::OP_SUB;
			4'b0010: begin
				alu_ctl.op = risc8_pkg::OP_SBC;
				alu_ctl.use_carry = 1'b1;
			end
			4'b1000: alu_ctl.op = risc8_pkg::OP_AND;
			4'b1001: alu_ctl.op = risc8_pkg::OP_EOR;
			4'b1010: alu_ctl.op = risc8_pkg::OP_OR;
			4'b1011: alu_ctl.op = risc8_pkg::OP_MOVE;
			default: begin
				alu_ctl.op = risc8_pkg::OP_SUB;
				alu_ctl.store = 1'b0;
			end
			endcase
		end
		risc8_pkg::CLASS_LDI: begin
			sel_a = rdi;
			alu_ctl.op = risc8_pkg::OP_MOVE_CONST;
			alu_ctl.dest = rdi;
			alu_ctl.store = 1'b1;
			alu_ctl.use_const = 1'b1;
			alu_ctl.const_val = k;
		end
		risc8_pkg::CLASS_RJMP: begin
			branch_req.jump = 1'b1;
			branch_req.offset = {{4{opcode[11]}}, opcode[11:0]};
		end
		risc8_pkg::CLASS_BRANCH: begin
			// BRBS has bit 10 clear, BRBC has it set
			branch_req.jump = 1'b1;
			branch_req.cond = 1'b1;
			branch_req.bit_sel = opcode[2:0];
			branch_req.polarity = opcode[10];
			branch_req.offset = {{9{opcode[9]}}, opcode[9:3]};
		end
		risc8_pkg::CLASS_OUT: begin
			// Rr of OUT sits in the Rd field
			sel_b = rd;
			if (state == risc8_pkg::SEQ_FIRST) begin
				// the ALU sees Rd on the next clock
				if (is_sreg_io)
					alu_ctl.op = risc8_pkg::OP_SREG_LOAD;
			end else if (!is_sreg_io) begin
				bus_req.addr = io_data_addr;
				bus_req.wen = 1'b1;
				bus_req.wdata = reg_a;
			end
		end
		risc8_pkg::CLASS_IN: begin
			if (state == risc8_pkg::SEQ_FIRST) begin
				if (!is_sreg_io) begin
					bus_req.addr = io_data_addr;
					bus_req.ren = 1'b1;
				end
			end else begin
				// read data arrives as a constant for Rd
				alu_ctl.store = 1'b1;
				alu_ctl.use_const = 1'b1;
				if (is_sreg_io) begin
					alu_ctl.op = risc8_pkg::OP_SREG_READ;
					alu_ctl.const_val = sreg_next;
				end else begin
					alu_ctl.op = risc8_pkg::OP_MOVE_CONST;
					alu_ctl.const_val = data_read;
				end
			end
		end
		default: begin
			// anything else retires as a no-op
		end
		endcase
	end

endmodule

/* design/risc8_pc.sv */
// ============================================================================
// Program counter of the RISC-8 core.
// pc is the fetch address for the next clock: PC plus one, the PC itself
// under hold, or a relative target for RJMP and taken branches. A branch
// tests the status value the ALU produces in the same clock.
// ============================================================================
`timescale 1ns/10ps

module risc8_pc (
	input logic clk,
	input logic reset,
	input logic hold,
	input risc8_pkg::branch_req_t branch_req,
	input risc8_pkg::byte_t sreg_next,
	output risc8_pkg::addr_t pc
);
	// address of the opcode now on cdata
	risc8_pkg::addr_t pc_q;
	logic taken;

	always_comb begin
		// taken when the status bit differs from the skip polarity
		taken = branch_req.jump &&
			(!branch_req.cond || (sreg_next[branch_req.bit_sel] != branch_req.polarity));
		if (hold)
			pc = pc_q;
		else if (taken)
			pc = pc_q + 16'd1 + branch_req.offset;
		else
			pc = pc_q + 16'd1;
	end

	always_ff @(posedge clk) begin
		// one below, so the first fetch is RESET_PC
		if (reset)
			pc_q <= risc8_pkg::RESET_PC - 16'd1;
		else
			pc_q <= pc;
	end

	// jumps are single cycle, hold only comes from IN and OUT
	a_hold_no_jump: assert property (@(posedge clk) disable iff (reset)
		!(hold && branch_req.jump));

endmodule

/* design/risc8_pkg.sv */
// ============================================================================
// Shared definitions of the two-stage RISC-8 core.
// Holds the widths, the ALU and sequencer encodings, the stage-to-stage
// structs and the I/O constants. RTL files refer to them by scoped name.
// ============================================================================
package risc8_pkg;

	// widths with a meaning of their own
	typedef logic [15:0] opcode_t;
	typedef logic [7:0] byte_t;
	typedef logic [15:0] addr_t;
	typedef logic [4:0] reg_sel_t;
	typedef logic [5:0] io_addr_t;

	// I/O space sits above the register file in data space
	localparam addr_t IO_BASE = 16'h0020;
	localparam io_addr_t SREG_IO = 6'h3F;
	localparam addr_t RESET_PC = 16'h0000;

	// status bit positions, bits 5 to 7 read as zero
	localparam int FLAG_C = 0;
	localparam int FLAG_Z = 1;
	localparam int FLAG_N = 2;
	localparam int FLAG_V = 3;
	localparam int FLAG_S = 4;

	typedef enum logic [3:0] {
		OP_ADD,
		OP_ADC,
		OP_SUB,
		OP_SBC,
		OP_AND,
		OP_OR,
		OP_EOR,
		OP_MOVE,
		OP_MOVE_CONST,
		OP_SREG_LOAD,
		OP_SREG_READ
	} alu_op_e;

	typedef enum logic {
		SEQ_FIRST,
		SEQ_SECOND
	} seq_state_e;

	typedef enum logic [2:0] {
		CLASS_ALU,
		CLASS_LDI,
		CLASS_RJMP,
		CLASS_BRANCH,
		CLASS_OUT,
		CLASS_IN,
		CLASS_NOP
	} instr_class_e;

	// first-stage results, latched by the ALU for the second stage
	typedef struct packed {
		alu_op_e op;
		reg_sel_t dest;
		logic store;
		logic use_carry;
		logic use_const;
		byte_t const_val;
	} alu_ctl_t;

	// next data bus cycle
	typedef struct packed {
		addr_t addr;
		logic ren;
		logic wen;
		byte_t wdata;
	} bus_req_t;

	// jump request, offset already sign extended to a word offset
	typedef struct packed {
		logic jump;
		logic cond;
		logic [2:0] bit_sel;
		logic polarity;
		addr_t offset;
	} branch_req_t;

endpackage

/* design/risc8_regs.sv */
// ============================================================================
// Register file of the RISC-8 core, 32 entries of one byte in flops.
// Both reads are registered, so data shows up one clock after the select.
// A write in the same clock to a selected register is passed through.
// ============================================================================
`timescale 1ns/10ps

module risc8_regs (
	input logic clk,
	input risc8_pkg::reg_sel_t sel_a,
	input risc8_pkg::reg_sel_t sel_b,
	output risc8_pkg::byte_t reg_a,
	output risc8_pkg::byte_t reg_b,
	input risc8_pkg::reg_sel_t wsel,
	input logic wen,
	input risc8_pkg::byte_t wdata
);
	risc8_pkg::byte_t rf [0:31];

	always_ff @(posedge clk) begin
		if (wen)
			rf[wsel] <= wdata;
		// bypass the ALU result that retires this clock
		if (wen && wsel == sel_a)
			reg_a <= wdata;
		else
			reg_a <= rf[sel_a];
		if (wen && wsel == sel_b)
			reg_b <= wdata;
		else
			reg_b <= rf[sel_b];
	end

endmodule

/* design/risc8_sequencer.sv */
// ============================================================================
// Two-cycle sequencer of the RISC-8 core.
// IN and OUT take a second clock: the opcode is held and the PC is kept
// while the first cycle runs. Out of reset the FSM sits in its second
// state on a held NOP, so the fetch of RESET_PC runs exactly once.
// ============================================================================
`timescale 1ns/10ps

module risc8_sequencer (
	input logic clk,
	input logic reset,
	input risc8_pkg::opcode_t cdata,
	input risc8_pkg::instr_class_e instr_class,
	output risc8_pkg::seq_state_e state,
	output risc8_pkg::opcode_t opcode,
	output logic hold
);
	risc8_pkg::seq_state_e state_q;
	risc8_pkg::opcode_t held_q;

	assign state = state_q;
	// second cycle re-runs the held opcode
	assign opcode = (state_q == risc8_pkg::SEQ_FIRST) ? cdata : held_q;
	// keep the PC while a bus instruction needs another clock
	assign hold = (state_q == risc8_pkg::SEQ_FIRST) &&
		(instr_class == risc8_pkg::CLASS_OUT || instr_class == risc8_pkg::CLASS_IN);

	always_ff @(posedge clk) begin
		if (reset) begin
			// 16'h0000 is the AVR NOP
			state_q <= risc8_pkg::SEQ_SECOND;
			held_q <= '0;
		end else if (hold) begin
			state_q <= risc8_pkg::SEQ_SECOND;
			held_q <= cdata;
		end else begin
			state_q <= risc8_pkg::SEQ_FIRST;
		end
	end

	// no instruction takes more than two clocks
	a_second_returns: assert property (@(posedge clk) disable iff (reset)
		state_q == risc8_pkg::SEQ_SECOND |=> state_q == risc8_pkg::SEQ_FIRST);

endmodule
